// ==== source/iq_cfg_pkg.sv ====
package iq_cfg_pkg;

    // --------------------
    // datapath widths
    // --------------------

    // width of one data word on the CDB and in the operands
    localparam int WORD_W = 32;

    // reorder-buffer tag width
    localparam int TAG_W = 5;

    // --------------------
    // issue ordering
    // --------------------

    // per-entry age counter, saturates at all ones
    localparam int AGE_W = 3;

endpackage

// ==== source/alu_uop_pkg.sv ====
package alu_uop_pkg;

    // --------------------
    // opcodes
    // --------------------

    localparam int OP_W = 3;

    localparam logic [OP_W-1:0] OP_ADD = 3'd0;
    localparam logic [OP_W-1:0] OP_SUB = 3'd1;
    localparam logic [OP_W-1:0] OP_AND = 3'd2;
    localparam logic [OP_W-1:0] OP_OR  = 3'd3;
    localparam logic [OP_W-1:0] OP_XOR = 3'd4;
    // shifts take the low 5 bits of operand 2
    localparam logic [OP_W-1:0] OP_SLL = 3'd5;
    localparam logic [OP_W-1:0] OP_SRL = 3'd6;
    // signed compare
    localparam logic [OP_W-1:0] OP_SLT = 3'd7;

    // --------------------
    // operand word
    // --------------------

    // pending operand: tag sits in the low bits
    typedef struct packed {
        logic [iq_cfg_pkg::WORD_W-iq_cfg_pkg::TAG_W-1:0] pad;
        logic [iq_cfg_pkg::TAG_W-1:0]                    tag;
    } operand_tag_t;

    // same word, read as value once ready and as tag while pending
    typedef union packed {
        logic [iq_cfg_pkg::WORD_W-1:0] val;
        operand_tag_t                  tag_view;
    } operand_u;

endpackage

// ==== source/iq_dispatch.sv ====
`timescale 1ns/1ps

module iq_dispatch #(
    parameter int IQ_SIZE = 4
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,

    // dispatch handshake
    input  logic               uop_valid_i,
    output logic               uop_ready_o,

    // slot freed by the issue stage
    input  logic [IQ_SIZE-1:0] issue_i,

    // one-hot write enable toward the entries
    output logic [IQ_SIZE-1:0] alloc_o
);

    logic [IQ_SIZE-1:0] occupied_q;
    logic [IQ_SIZE-1:0] free_w;
    logic [IQ_SIZE-1:0] lowest_free;
    logic               uop_fire;

    // --------------------
    // slot search
    // --------------------

    assign free_w = ~occupied_q;

    // isolate the lowest set bit of the free vector
    assign lowest_free = free_w & (~free_w + 1'b1);

    // ready only looks at the queue state, never at valid
    assign uop_ready_o = |free_w;

    assign uop_fire = uop_valid_i & uop_ready_o;

    assign alloc_o = uop_fire ? lowest_free : '0;

    // --------------------
    // occupancy
    // --------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupied_q <= '0;
        end else if (flush_i) begin
            // flush drops every entry, including one being written
            occupied_q <= '0;
        end else begin
            // a slot is never allocated and issued in the same cycle
            occupied_q <= (occupied_q | alloc_o) & ~issue_i;
        end
    end

endmodule

// ==== source/iq_entry.sv ====
`timescale 1ns/1ps

module iq_entry #(
    parameter int CDB_COUNT = 2
) (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,
    input  logic                                         alloc_i,
    input  logic                                         issue_i,

    // micro-op written on alloc
    input  logic [alu_uop_pkg::OP_W-1:0]                 op_i,
    input  logic [iq_cfg_pkg::TAG_W-1:0]                 dst_i,
    input  alu_uop_pkg::operand_u                        src1_i,
    input  logic                                         src1_rdy_i,
    input  alu_uop_pkg::operand_u                        src2_i,
    input  logic                                         src2_rdy_i,

    // external result buses
    input  logic [CDB_COUNT-1:0]                         cdb_valid_i,
    input  logic [CDB_COUNT-1:0][iq_cfg_pkg::TAG_W-1:0]  cdb_tag_i,
    input  logic [CDB_COUNT-1:0][iq_cfg_pkg::WORD_W-1:0] cdb_data_i,

    // own result, valid only on a transfer
    input  logic                                         res_valid_i,
    input  logic [iq_cfg_pkg::TAG_W-1:0]                 res_tag_i,
    input  logic [iq_cfg_pkg::WORD_W-1:0]                res_data_i,

    output logic                                         ready_o,
    output logic [iq_cfg_pkg::AGE_W-1:0]                 age_o,
    output logic [alu_uop_pkg::OP_W-1:0]                 op_o,
    output logic [iq_cfg_pkg::TAG_W-1:0]                 dst_o,
    output alu_uop_pkg::operand_u                        src1_o,
    output alu_uop_pkg::operand_u                        src2_o
);

    localparam logic [iq_cfg_pkg::AGE_W-1:0] AGE_MAX = '1;

    logic                              valid_q;
    logic                              rdy1_q;
    logic                              rdy2_q;
    logic [iq_cfg_pkg::AGE_W-1:0]      age_q;
    logic [alu_uop_pkg::OP_W-1:0]      op_q;
    logic [iq_cfg_pkg::TAG_W-1:0]      dst_q;
    alu_uop_pkg::operand_u             src1_q;
    alu_uop_pkg::operand_u             src2_q;

    alu_uop_pkg::operand_u             src1_sel;
    alu_uop_pkg::operand_u             src2_sel;
    logic                              rdy1_sel;
    logic                              rdy2_sel;
    logic [iq_cfg_pkg::WORD_W:0]       woken1;
    logic [iq_cfg_pkg::WORD_W:0]       woken2;

    // returns {ready, value} after tag match against all broadcasts
    function automatic logic [iq_cfg_pkg::WORD_W:0] wake(
        input alu_uop_pkg::operand_u opnd,
        input logic                  rdy
    );
        logic [iq_cfg_pkg::WORD_W:0] res;
        res = {rdy, opnd.val};
        for (int c = 0; c < CDB_COUNT; c++) begin
            if (!rdy && cdb_valid_i[c] && (cdb_tag_i[c] == opnd.tag_view.tag)) begin
                res = {1'b1, cdb_data_i[c]};
            end
        end
        if (!rdy && res_valid_i && (res_tag_i == opnd.tag_view.tag)) begin
            res = {1'b1, res_data_i};
        end
        return res;
    endfunction

    // --------------------
    // wakeup
    // --------------------

    // incoming operands are snooped too, so a same-cycle broadcast is caught
    always_comb begin
        src1_sel = alloc_i ? src1_i : src1_q;
        src2_sel = alloc_i ? src2_i : src2_q;
        rdy1_sel = alloc_i ? src1_rdy_i : rdy1_q;
        rdy2_sel = alloc_i ? src2_rdy_i : rdy2_q;
        woken1   = wake(src1_sel, rdy1_sel);
        woken2   = wake(src2_sel, rdy2_sel);
    end

    // --------------------
    // state
    // --------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            rdy1_q  <= 1'b0;
            rdy2_q  <= 1'b0;
            age_q   <= '0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            age_q   <= '0;
        end else begin
            if (alloc_i) begin
                valid_q <= 1'b1;
            end else if (issue_i) begin
                valid_q <= 1'b0;
            end
            if (alloc_i || valid_q) begin
                rdy1_q <= woken1[iq_cfg_pkg::WORD_W];
                rdy2_q <= woken2[iq_cfg_pkg::WORD_W];
            end
            // ages only while waiting to issue, back-pressure included
            if (ready_o && !issue_i) begin
                age_q <= (age_q == AGE_MAX) ? age_q : age_q + 1'b1;
            end else begin
                age_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            op_q  <= op_i;
            dst_q <= dst_i;
        end
        if (alloc_i || valid_q) begin
            src1_q <= woken1[iq_cfg_pkg::WORD_W-1:0];
            src2_q <= woken2[iq_cfg_pkg::WORD_W-1:0];
        end
    end

    assign ready_o = valid_q & rdy1_q & rdy2_q;
    assign age_o   = age_q;
    assign op_o    = op_q;
    assign dst_o   = dst_q;
    assign src1_o  = src1_q;
    assign src2_o  = src2_q;

endmodule

// ==== source/iq_issue_exec.sv ====
`timescale 1ns/1ps

module iq_issue_exec #(
    parameter int IQ_SIZE = 4
) (
    input  logic                                       clk,
    input  logic                                       rst_n_i,
    input  logic                                       flush_i,

    // per-entry status
    input  logic [IQ_SIZE-1:0]                         ready_i,
    input  logic [IQ_SIZE-1:0][iq_cfg_pkg::AGE_W-1:0]  age_i,

    // per-entry payload
    input  logic [IQ_SIZE-1:0][alu_uop_pkg::OP_W-1:0]  op_i,
    input  logic [IQ_SIZE-1:0][iq_cfg_pkg::TAG_W-1:0]  dst_i,
    input  alu_uop_pkg::operand_u [IQ_SIZE-1:0]        src1_i,
    input  alu_uop_pkg::operand_u [IQ_SIZE-1:0]        src2_i,

    output logic [IQ_SIZE-1:0]                         issue_o,

    // result handshake
    output logic                                       result_valid_o,
    input  logic                                       result_ready_i,
    output logic [iq_cfg_pkg::TAG_W-1:0]               result_tag_o,
    output logic [iq_cfg_pkg::WORD_W-1:0]              result_data_o
);

    localparam int IDX_W = (IQ_SIZE > 1) ? $clog2(IQ_SIZE) : 1;

    logic [IDX_W-1:0]              best_idx;
    logic [iq_cfg_pkg::AGE_W-1:0]  best_age;
    logic                          found;
    logic                          can_accept;
    logic                          issue_fire;

    logic [alu_uop_pkg::OP_W-1:0]  op_sel;
    logic [iq_cfg_pkg::WORD_W-1:0] opa;
    logic [iq_cfg_pkg::WORD_W-1:0] opb;
    logic [iq_cfg_pkg::WORD_W-1:0] alu_res;

    logic                          res_valid_q;
    logic [iq_cfg_pkg::TAG_W-1:0]  res_tag_q;
    logic [iq_cfg_pkg::WORD_W-1:0] res_data_q;

    // --------------------
    // oldest-ready select
    // --------------------

    // strict compare keeps ties on the lower index
    always_comb begin
        best_idx = '0;
        best_age = '0;
        found    = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (ready_i[i] && (!found || (age_i[i] > best_age))) begin
                best_idx = IDX_W'(i);
                best_age = age_i[i];
                found    = 1'b1;
            end
        end
    end

    // result slot is free now or empties at this edge
    assign can_accept = !res_valid_q || result_ready_i;
    assign issue_fire = found && can_accept;

    always_comb begin
        issue_o           = '0;
        issue_o[best_idx] = issue_fire;
    end

    // --------------------
    // ALU
    // --------------------

    assign op_sel = op_i[best_idx];
    assign opa    = src1_i[best_idx].val;
    assign opb    = src2_i[best_idx].val;

    always_comb begin
        alu_res = '0;
        case (op_sel)
            alu_uop_pkg::OP_ADD: alu_res = opa + opb;
            alu_uop_pkg::OP_SUB: alu_res = opa - opb;
            alu_uop_pkg::OP_AND: alu_res = opa & opb;
            alu_uop_pkg::OP_OR:  alu_res = opa | opb;
            alu_uop_pkg::OP_XOR: alu_res = opa ^ opb;
            alu_uop_pkg::OP_SLL: alu_res = opa << opb[4:0];
            alu_uop_pkg::OP_SRL: alu_res = opa >> opb[4:0];
            alu_uop_pkg::OP_SLT: begin
                alu_res = {{(iq_cfg_pkg::WORD_W-1){1'b0}}, ($signed(opa) < $signed(opb))};
            end
            default: alu_res = '0;
        endcase
    end

    // --------------------
    // result register
    // --------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            // held result is dropped along with the queue
            res_valid_q <= 1'b0;
        end else if (issue_fire) begin
            res_valid_q <= 1'b1;
        end else if (result_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    // payload only moves when a new op issues, so it holds under stall
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            res_tag_q  <= dst_i[best_idx];
            res_data_q <= alu_res;
        end
    end

    assign result_valid_o = res_valid_q;
    assign result_tag_o   = res_tag_q;
    assign result_data_o  = res_data_q;

endmodule

// ==== source/alu_iq_top.sv ====
`timescale 1ns/1ps

module alu_iq_top #(
    parameter int IQ_SIZE   = 4,
    parameter int CDB_COUNT = 2
) (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,

    // dispatch
    input  logic                                         uop_valid_i,
    output logic                                         uop_ready_o,
    input  logic [alu_uop_pkg::OP_W-1:0]                 uop_op_i,
    input  logic [iq_cfg_pkg::TAG_W-1:0]                 uop_dst_i,
    input  alu_uop_pkg::operand_u                        uop_src1_i,
    input  logic                                         uop_src1_rdy_i,
    input  alu_uop_pkg::operand_u                        uop_src2_i,
    input  logic                                         uop_src2_rdy_i,

    // CDB
    input  logic [CDB_COUNT-1:0]                         cdb_valid_i,
    input  logic [CDB_COUNT-1:0][iq_cfg_pkg::TAG_W-1:0]  cdb_tag_i,
    input  logic [CDB_COUNT-1:0][iq_cfg_pkg::WORD_W-1:0] cdb_data_i,

    // result
    output logic                                         result_valid_o,
    input  logic                                         result_ready_i,
    output logic [iq_cfg_pkg::TAG_W-1:0]                 result_tag_o,
    output logic [iq_cfg_pkg::WORD_W-1:0]                result_data_o
);

    logic [IQ_SIZE-1:0]                        alloc_w;
    logic [IQ_SIZE-1:0]                        issue_w;
    logic [IQ_SIZE-1:0]                        ready_w;
    logic [IQ_SIZE-1:0][iq_cfg_pkg::AGE_W-1:0] age_w;
    logic [IQ_SIZE-1:0][alu_uop_pkg::OP_W-1:0] op_w;
    logic [IQ_SIZE-1:0][iq_cfg_pkg::TAG_W-1:0] dst_w;
    alu_uop_pkg::operand_u [IQ_SIZE-1:0]       src1_w;
    alu_uop_pkg::operand_u [IQ_SIZE-1:0]       src2_w;
    logic                                      res_xfer;

    // own result wakes entries only when it actually leaves
    assign res_xfer = result_valid_o & result_ready_i;

    iq_dispatch #(
        .IQ_SIZE(IQ_SIZE)
    ) u_dispatch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .uop_valid_i (uop_valid_i),
        .uop_ready_o (uop_ready_o),
        .issue_i     (issue_w),
        .alloc_o     (alloc_w)
    );

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry #(
            .CDB_COUNT(CDB_COUNT)
        ) u_entry (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .alloc_i     (alloc_w[i]),
            .issue_i     (issue_w[i]),
            .op_i        (uop_op_i),
            .dst_i       (uop_dst_i),
            .src1_i      (uop_src1_i),
            .src1_rdy_i  (uop_src1_rdy_i),
            .src2_i      (uop_src2_i),
            .src2_rdy_i  (uop_src2_rdy_i),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .res_valid_i (res_xfer),
            .res_tag_i   (result_tag_o),
            .res_data_i  (result_data_o),
            .ready_o     (ready_w[i]),
            .age_o       (age_w[i]),
            .op_o        (op_w[i]),
            .dst_o       (dst_w[i]),
            .src1_o      (src1_w[i]),
            .src2_o      (src2_w[i])
        );
    end

    iq_issue_exec #(
        .IQ_SIZE(IQ_SIZE)
    ) u_issue_exec (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .ready_i        (ready_w),
        .age_i          (age_w),
        .op_i           (op_w),
        .dst_i          (dst_w),
        .src1_i         (src1_w),
        .src2_i         (src2_w),
        .issue_o        (issue_w),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_tag_o   (result_tag_o),
        .result_data_o  (result_data_o)
    );

endmodule

// ==== test/alu_iq_chk.sv ====
`timescale 1ns/1ps

module alu_iq_chk (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          flush_i,
    input logic                          uop_ready_i,
    input logic                          res_valid_i,
    input logic                          res_ready_i,
    input logic [iq_cfg_pkg::TAG_W-1:0]  res_tag_i,
    input logic [iq_cfg_pkg::WORD_W-1:0] res_data_i
);

    // --------------------
    // result port
    // --------------------

    // held result stays put under back-pressure
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_i && !res_ready_i && !flush_i |=>
            res_valid_i && $stable(res_tag_i) && $stable(res_data_i))
        else $error("result outputs changed while stalled");

    // flush drops the held result
    a_flush_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !res_valid_i)
        else $error("result still valid after flush");

    // queue empty out of reset
    a_ready_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> uop_ready_i)
        else $error("uop_ready_o low after reset");

endmodule

bind alu_iq_top alu_iq_chk u_chk (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .uop_ready_i (uop_ready_o),
    .res_valid_i (result_valid_o),
    .res_ready_i (result_ready_i),
    .res_tag_i   (result_tag_o),
    .res_data_i  (result_data_o)
);

// ==== test/tb_alu_iq.sv ====
`timescale 1ns/1ps

module tb_alu_iq;

    localparam int IQ_SIZE   = 4;
    localparam int CDB_COUNT = 2;
    localparam int WORD_W    = iq_cfg_pkg::WORD_W;
    localparam int TAG_W     = iq_cfg_pkg::TAG_W;
    localparam int N_TAGS    = 1 << TAG_W;
    localparam int BUS_W     = (CDB_COUNT > 1) ? $clog2(CDB_COUNT) : 1;

    logic                             clk;
    logic                             rst_n_i;
    logic                             flush_i;
    logic                             uop_valid_i;
    logic                             uop_ready_o;
    logic [alu_uop_pkg::OP_W-1:0]     uop_op_i;
    logic [TAG_W-1:0]                 uop_dst_i;
    alu_uop_pkg::operand_u            uop_src1_i;
    logic                             uop_src1_rdy_i;
    alu_uop_pkg::operand_u            uop_src2_i;
    logic                             uop_src2_rdy_i;
    logic [CDB_COUNT-1:0]             cdb_valid_i;
    logic [CDB_COUNT-1:0][TAG_W-1:0]  cdb_tag_i;
    logic [CDB_COUNT-1:0][WORD_W-1:0] cdb_data_i;
    logic                             result_valid_o;
    logic                             result_ready_i;
    logic [TAG_W-1:0]                 result_tag_o;
    logic [WORD_W-1:0]                result_data_o;

    // scoreboard, indexed by result tag
    logic [WORD_W-1:0] exp_data [N_TAGS];
    int                exp_ord  [N_TAGS];
    logic              exp_live [N_TAGS];
    int                pending;
    int                arrivals;
    int                errors;
    int                checks;
    int                tests_run;
    int                errors_at_start;

    logic [31:0]       rng_state;
    logic              hold_ready;
    logic              was_stalled;
    logic [TAG_W-1:0]  prev_tag;
    logic [WORD_W-1:0] prev_data;

    alu_iq_top #(
        .IQ_SIZE  (IQ_SIZE),
        .CDB_COUNT(CDB_COUNT)
    ) UUT (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, expv);
        end
    endtask

    task automatic clear_scoreboard();
        foreach (exp_live[t]) begin
            exp_live[t] = 1'b0;
        end
        pending = 0;
    endtask

    task automatic record_result(input logic [TAG_W-1:0] tag, input logic [WORD_W-1:0] data);
        if (!exp_live[tag]) begin
            errors++;
            $display("unexpected result with tag %0d at %0t", tag, $time);
        end else begin
            arrivals++;
            check_value("result_data_o", data, exp_data[tag]);
            if (exp_ord[tag] != 0) begin
                check_value("result order", WORD_W'(arrivals), WORD_W'(exp_ord[tag]));
            end
            exp_live[tag] = 1'b0;
            pending--;
        end
    endtask

    // --------------------
    // one clock cycle
    // --------------------

    // advance to the falling edge, then watch the result port
    task automatic tick();
        @(negedge clk);
        if (was_stalled && !flush_i) begin
            check_value("result_valid_o", WORD_W'(result_valid_o), WORD_W'(1));
            check_value("result_tag_o", WORD_W'(result_tag_o), WORD_W'(prev_tag));
            check_value("result_data_o", result_data_o, prev_data);
        end
        cdb_valid_i    = '0;
        flush_i        = 1'b0;
        rng_state      = lcg_next(rng_state);
        result_ready_i = !hold_ready && (rng_state[17:16] != 2'b00);
        // transfer takes place at the coming rising edge
        if (result_valid_o && result_ready_i) begin
            record_result(result_tag_o, result_data_o);
        end
        was_stalled = result_valid_o && !result_ready_i;
        prev_tag    = result_tag_o;
        prev_data   = result_data_o;
    endtask

    task automatic dispatch_uop(input logic [2:0] op, input logic [TAG_W-1:0] dst,
                                input logic [WORD_W-1:0] s1, input logic r1,
                                input logic [WORD_W-1:0] s2, input logic r2,
                                input logic [WORD_W-1:0] expv, input int ord);
        int waited;
        exp_live[dst]    = 1'b1;
        exp_data[dst]    = expv;
        exp_ord[dst]     = ord;
        pending++;
        uop_op_i         = op;
        uop_dst_i        = dst;
        uop_src1_i.val   = s1;
        uop_src1_rdy_i   = r1;
        uop_src2_i.val   = s2;
        uop_src2_rdy_i   = r2;
        uop_valid_i      = 1'b1;
        waited = 0;
        while (!uop_ready_o && waited < 100) begin
            tick();
            waited++;
        end
        if (!uop_ready_o) begin
            errors++;
            $display("dispatch of tag %0d was not accepted within 100 cycles", dst);
        end
        tick();
        uop_valid_i = 1'b0;
    endtask

    // armed here, sent together with the next cycle
    task automatic drive_cdb(input logic [BUS_W-1:0] bus, input logic [TAG_W-1:0] tag,
                             input logic [WORD_W-1:0] data);
        cdb_valid_i[bus] = 1'b1;
        cdb_tag_i[bus]   = tag;
        cdb_data_i[bus]  = data;
    endtask

    task automatic stall_cycles(input int n, input logic hold, input logic check_ready,
                                input logic ready_exp);
        hold_ready = hold;
        for (int i = 0; i < n; i++) begin
            tick();
        end
        if (check_ready) begin
            check_value("uop_ready_o", WORD_W'(uop_ready_o), WORD_W'(ready_exp));
        end
    endtask

    // flushed micro-ops never return a result
    task automatic flush_queue();
        flush_i = 1'b1;
        clear_scoreboard();
        tick();
    endtask

    task automatic finish_test(input int num);
        int waited;
        waited = 0;
        while (pending > 0 && waited < 300) begin
            tick();
            waited++;
        end
        if (pending > 0) begin
            errors++;
            $display("test %0d: %0d results still missing after 300 cycles", num, pending);
            clear_scoreboard();
        end
        tests_run++;
        $display("test %0d finished with %0d errors", num, errors - errors_at_start);
        errors_at_start = errors;
        arrivals        = 0;
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        int          fd;
        int          cur_test;
        int          num;
        int          n;
        string       line;
        string       kind;
        logic [31:0] f [8];

        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        uop_valid_i    = 1'b0;
        uop_op_i       = '0;
        uop_dst_i      = '0;
        uop_src1_i     = '0;
        uop_src1_rdy_i = 1'b0;
        uop_src2_i     = '0;
        uop_src2_rdy_i = 1'b0;
        cdb_valid_i    = '0;
        cdb_tag_i      = '0;
        cdb_data_i     = '0;
        result_ready_i = 1'b0;
        rng_state      = 32'd20827;
        hold_ready     = 1'b0;
        was_stalled    = 1'b0;
        prev_tag       = '0;
        prev_data      = '0;
        arrivals       = 0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        errors_at_start = 0;
        clear_scoreboard();

        repeat (16) tick();
        rst_n_i = 1'b1;

        fd = $fopen("test/alu_iq_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open test/alu_iq_golden.txt");
        end else begin
            cur_test = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h", num, kind,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n != 10) begin
                    errors++;
                    $display("malformed line in golden file: %s", line);
                    continue;
                end
                if (num != cur_test && cur_test != 0) begin
                    finish_test(cur_test);
                end
                cur_test = num;
                if (kind == "dispatch") begin
                    dispatch_uop(f[0][2:0], f[1][TAG_W-1:0], f[2], f[3][0], f[4], f[5][0],
                                 f[6], int'(f[7]));
                end else if (kind == "cdb") begin
                    drive_cdb(f[0][BUS_W-1:0], f[1][TAG_W-1:0], f[2]);
                end else if (kind == "stall") begin
                    stall_cycles(int'(f[2]), f[3][0], f[4][0], f[6][0]);
                end else if (kind == "flush") begin
                    flush_queue();
                end else begin
                    errors++;
                    $display("unknown kind %s in golden file", kind);
                end
            end
            if (cur_test != 0) begin
                finish_test(cur_test);
            end
            $fclose(fd);
        end

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== test/alu_iq_golden.txt ====
# test kind op dst src1 rdy1 src2 rdy2 exp ord (test in decimal, all else hex)
# cdb: op=bus dst=tag src1=data; stall: src1=cycles rdy1=hold src2=check exp=uop_ready
1 dispatch 0 01 00000005 1 00000007 1 0000000c 0
1 dispatch 1 02 00000003 1 00000005 1 fffffffe 0
1 dispatch 2 03 f0f0f0f0 1 ff00ff00 1 f000f000 0
1 dispatch 3 04 0f000000 1 000000f0 1 0f0000f0 0
1 dispatch 4 05 aaaaaaaa 1 ffff0000 1 5555aaaa 0
1 dispatch 5 06 00000001 1 00000024 1 00000010 0
1 dispatch 6 07 80000000 1 0000001f 1 00000001 0
1 dispatch 7 08 fffffffb 1 00000003 1 00000001 0
1 dispatch 7 09 00000005 1 ffffffff 1 00000000 0
2 dispatch 0 03 00000011 0 00000005 1 00000105 0
2 stall    0 00 00000004 0 00000000 0 00000000 0
2 cdb      0 11 00000100 0 00000000 0 00000000 0
2 stall    0 00 00000001 0 00000000 0 00000000 0
2 cdb      1 12 000000f0 0 00000000 0 00000000 0
2 dispatch 2 04 000000ff 1 00000012 0 000000f0 0
3 dispatch 0 0a 00000010 1 00000020 1 00000030 1
3 dispatch 1 0b 0000000a 0 00000008 1 00000028 2
3 dispatch 3 0c 0000000b 0 00000100 1 00000128 3
4 stall    0 00 00000001 1 00000000 0 00000000 0
4 dispatch 0 0d 00000014 0 00000001 1 00000235 0
4 dispatch 1 0e 00000014 0 00000001 1 00000233 0
4 dispatch 2 0f 00000014 0 000000ff 1 00000034 0
4 stall    0 00 00000000 1 00000001 0 00000001 0
4 dispatch 3 10 00000014 0 00001000 1 00001234 0
4 stall    0 00 00000000 1 00000001 0 00000000 0
4 cdb      1 14 00000234 0 00000000 0 00000000 0
4 stall    0 00 00000006 1 00000001 0 00000001 0
4 stall    0 00 00000001 0 00000000 0 00000000 0
5 stall    0 00 00000001 1 00000000 0 00000000 0
5 dispatch 0 11 00000001 1 00000001 1 00000002 1
5 dispatch 1 12 00000050 1 00000010 1 00000040 2
5 dispatch 0 13 00000019 0 00000003 1 0000000a 3
5 stall    0 00 00000002 1 00000000 0 00000000 0
5 cdb      0 19 00000007 0 00000000 0 00000000 0
5 stall    0 00 00000001 1 00000000 0 00000000 0
5 stall    0 00 00000001 0 00000000 0 00000000 0
6 stall    0 00 00000001 1 00000000 0 00000000 0
6 dispatch 0 15 00000002 1 00000002 1 00000004 0
6 dispatch 0 16 0000001a 0 00000001 1 00000000 0
6 dispatch 1 17 0000001a 0 00000002 1 00000000 0
6 flush    0 00 00000000 0 00000000 0 00000000 0
6 cdb      0 1a 00000005 0 00000000 0 00000000 0
6 stall    0 00 00000008 0 00000001 0 00000001 0

// ==== compile.f ====
source/iq_cfg_pkg.sv
source/alu_uop_pkg.sv
source/iq_dispatch.sv
source/iq_entry.sv
source/iq_issue_exec.sv
source/alu_iq_top.sv
test/alu_iq_chk.sv
test/tb_alu_iq.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_alu_iq

./obj_dir/Vtb_alu_iq > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
exit 1
